// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_issue_stage
FLIST     ?= issue_stage.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+100

SOURCES := $(filter %.sv %.v,$(shell cat $(FLIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN) $(SIM_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx 'RESULT: PASS'

clean:
	rm -rf $(BUILD_DIR)

// File: busy_table.sv
`default_nettype none
`timescale 1ns/100ps

module busy_table #(
    parameter int PRF_COUNT = 64
) (
    input  wire                         aclk,
    input  wire                         rst_n_i,
    input  wire                         flush_i,
    input  wire                         set_i,
    input  wire [$clog2(PRF_COUNT)-1:0] set_rd_i,
    input  wire                         wb_valid_i,
    input  wire [$clog2(PRF_COUNT)-1:0] wb_rd_i,
    input  wire [$clog2(PRF_COUNT)-1:0] src_a_i,
    input  wire [$clog2(PRF_COUNT)-1:0] src_b_i,
    output logic                        src_a_rdy_o,
    output logic                        src_b_rdy_o
);

    localparam int RW = $clog2(PRF_COUNT);

    // one bit per physical register, set while a producer is in flight
    logic [PRF_COUNT-1:0] busy_q;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            busy_q <= '0;
        end else if (flush_i) begin
            busy_q <= '0;
        end else begin
            if (wb_valid_i) begin
                busy_q[wb_rd_i] <= 1'b0;
            end
            // a new producer of the same register wins over the writeback
            if (set_i && (set_rd_i != RW'(0))) begin
                busy_q[set_rd_i] <= 1'b1;
            end
        end
    end

    // register 0 is always ready, writeback in this cycle is bypassed
    assign src_a_rdy_o = (src_a_i == RW'(0)) || !busy_q[src_a_i]
                         || (wb_valid_i && (wb_rd_i == src_a_i));
    assign src_b_rdy_o = (src_b_i == RW'(0)) || !busy_q[src_b_i]
                         || (wb_valid_i && (wb_rd_i == src_b_i));

endmodule

`default_nettype wire

// File: iss_csr.sv
`default_nettype none
`timescale 1ns/100ps

module iss_csr import iss_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                             aclk,
    input  wire                             rst_n_i,
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire [APB_AW-1:0]                paddr_i,
    input  wire [APB_DW-1:0]                pwdata_i,
    output logic [APB_DW-1:0]               prdata_o,
    input  wire [$clog2(QUEUE_DEPTH):0]     occupancy_i,
    input  wire                             issue_fire_i,
    output logic                            issue_en_o,
    output logic                            flush_o
);

    logic              wr_access;
    logic              en_q;
    logic              flush_q;
    logic [APB_DW-1:0] issued_q;

    // zero wait states, a write lands at the edge ending the access phase
    assign wr_access = psel_i && penable_i && pwrite_i;

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
        end else if (wr_access && (paddr_i == CSR_CTRL_OFS)) begin
            en_q <= pwdata_i[0];
        end
    end

    // flush is high only for the cycle after the write
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            flush_q <= 1'b0;
        end else begin
            flush_q <= wr_access && (paddr_i == CSR_FLUSH_OFS) && pwdata_i[0];
        end
    end

    // issue counter, any write clears it
    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            issued_q <= '0;
        end else if (wr_access && (paddr_i == CSR_ISSUED_OFS)) begin
            issued_q <= '0;
        end else if (issue_fire_i) begin
            issued_q <= issued_q + 1'b1;
        end
    end

    assign issue_en_o = en_q;
    assign flush_o    = flush_q;

    // read data, unmapped offsets read as zero
    always_comb begin
        case (paddr_i)
            CSR_CTRL_OFS: begin
                prdata_o = {{(APB_DW-1){1'b0}}, en_q};
            end
            CSR_STATUS_OFS: begin
                prdata_o = APB_DW'(occupancy_i);
            end
            CSR_ISSUED_OFS: begin
                prdata_o = issued_q;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: iss_pkg.sv
`default_nettype none

package iss_pkg;

    // micro-op tag
    localparam int TAG_W = 6;
    typedef logic [TAG_W-1:0] tag_t;

    // defaults picked up by the top level parameters
    localparam int DEF_QUEUE_DEPTH = 8;
    localparam int DEF_PRF_COUNT   = 64;

    // APB register block
    localparam int APB_AW = 4;
    localparam int APB_DW = 32;

    localparam logic [APB_AW-1:0] CSR_CTRL_OFS   = 4'd0;
    localparam logic [APB_AW-1:0] CSR_FLUSH_OFS  = 4'd4;
    localparam logic [APB_AW-1:0] CSR_STATUS_OFS = 4'd8;
    localparam logic [APB_AW-1:0] CSR_ISSUED_OFS = 4'd12;

endpackage

`default_nettype wire

// File: issue_queue.sv
`default_nettype none
`timescale 1ns/100ps

module issue_queue import iss_pkg::*; #(
    parameter int QUEUE_DEPTH = 8,
    parameter int PRF_COUNT   = 64
) (
    input  wire                             aclk,
    input  wire                             rst_n_i,
    input  wire                             flush_i,
    input  wire                             issue_en_i,
    input  wire                             disp_valid_i,
    input  tag_t                            disp_tag_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_rd_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_src_a_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_src_b_i,
    input  wire                             src_a_rdy_i,
    input  wire                             src_b_rdy_i,
    output logic                            disp_ready_o,
    output logic                            alloc_o,
    input  wire                             wb_valid_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     wb_rd_i,
    output logic                            iss_valid_o,
    output tag_t                            iss_tag_o,
    output logic [$clog2(PRF_COUNT)-1:0]    iss_rd_o,
    input  wire                             iss_ready_i,
    output logic                            issue_fire_o,
    output logic [$clog2(QUEUE_DEPTH):0]    occupancy_o
);

    localparam int RW = $clog2(PRF_COUNT);
    localparam int IW = $clog2(QUEUE_DEPTH);
    localparam int CW = IW + 1;

    // entry payload, index 0 is the oldest
    tag_t          tag_q   [QUEUE_DEPTH];
    logic [RW-1:0] rd_q    [QUEUE_DEPTH];
    logic [RW-1:0] src_a_q [QUEUE_DEPTH];
    logic [RW-1:0] src_b_q [QUEUE_DEPTH];
    logic          rdy_a_q [QUEUE_DEPTH];
    logic          rdy_b_q [QUEUE_DEPTH];

    logic [CW-1:0]          count_q;
    logic [CW-1:0]          wr_pos;
    logic [QUEUE_DEPTH-1:0] after_sel;
    logic [IW-1:0]          sel_idx;
    logic                   sel_found;
    logic                   fire;

    // oldest entry with both sources ready, entries below count_q are valid
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        after_sel = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (!sel_found && (CW'(i) < count_q) && rdy_a_q[i] && rdy_b_q[i]) begin
                sel_found = 1'b1;
                sel_idx   = IW'(i);
            end
            after_sel[i] = sel_found;
        end
    end

    assign iss_valid_o  = issue_en_i && sel_found;
    assign iss_tag_o    = tag_q[sel_idx];
    assign iss_rd_o     = rd_q[sel_idx];
    assign fire         = iss_valid_o && iss_ready_i;
    assign issue_fire_o = fire;

    assign disp_ready_o = (count_q != CW'(QUEUE_DEPTH));
    assign alloc_o      = disp_valid_i && disp_ready_o;
    assign occupancy_o  = count_q;

    // new entry lands behind the survivors of this cycle
    assign wr_pos = count_q - CW'(fire);

    always_ff @(posedge aclk) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else if (flush_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + CW'(alloc_o) - CW'(fire);
        end
    end

    for (genvar i = 0; i < QUEUE_DEPTH; i++) begin : g_entry
        localparam int NXT = (i < QUEUE_DEPTH - 1) ? i + 1 : i;

        logic take_nxt;
        tag_t          mv_tag;
        logic [RW-1:0] mv_rd;
        logic [RW-1:0] mv_a;
        logic [RW-1:0] mv_b;
        logic          mv_rdy_a;
        logic          mv_rdy_b;

        // compaction pulls the younger neighbour into the freed slot
        assign take_nxt = fire && after_sel[i];
        assign mv_tag   = take_nxt ? tag_q[NXT]   : tag_q[i];
        assign mv_rd    = take_nxt ? rd_q[NXT]    : rd_q[i];
        assign mv_a     = take_nxt ? src_a_q[NXT] : src_a_q[i];
        assign mv_b     = take_nxt ? src_b_q[NXT] : src_b_q[i];
        assign mv_rdy_a = take_nxt ? rdy_a_q[NXT] : rdy_a_q[i];
        assign mv_rdy_b = take_nxt ? rdy_b_q[NXT] : rdy_b_q[i];

        always_ff @(posedge aclk) begin
            if (alloc_o && (wr_pos == CW'(i))) begin
                tag_q[i]   <= disp_tag_i;
                rd_q[i]    <= disp_rd_i;
                src_a_q[i] <= disp_src_a_i;
                src_b_q[i] <= disp_src_b_i;
                rdy_a_q[i] <= src_a_rdy_i;
                rdy_b_q[i] <= src_b_rdy_i;
            end else begin
                tag_q[i]   <= mv_tag;
                rd_q[i]    <= mv_rd;
                src_a_q[i] <= mv_a;
                src_b_q[i] <= mv_b;
                // wakeup snoop on the writeback port
                rdy_a_q[i] <= mv_rdy_a || (wb_valid_i && (wb_rd_i == mv_a));
                rdy_b_q[i] <= mv_rdy_b || (wb_valid_i && (wb_rd_i == mv_b));
            end
        end
    end

endmodule

`default_nettype wire

// File: issue_stage.f
iss_pkg.sv
busy_table.sv
issue_queue.sv
iss_csr.sv
issue_stage.sv
tb_issue_props.sv
tb_issue_stage.sv

// File: issue_stage.sv
`default_nettype none
`timescale 1ns/100ps

module issue_stage import iss_pkg::*; #(
    parameter int QUEUE_DEPTH = DEF_QUEUE_DEPTH,
    parameter int PRF_COUNT   = DEF_PRF_COUNT
) (
    input  wire                             aclk,
    input  wire                             rst_n_i,
    // APB control port
    input  wire                             psel_i,
    input  wire                             penable_i,
    input  wire                             pwrite_i,
    input  wire [APB_AW-1:0]                paddr_i,
    input  wire [APB_DW-1:0]                pwdata_i,
    output logic [APB_DW-1:0]               prdata_o,
    // dispatch
    input  wire                             disp_valid_i,
    input  tag_t                            disp_tag_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_rd_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_src_a_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     disp_src_b_i,
    output logic                            disp_ready_o,
    // writeback
    input  wire                             wb_valid_i,
    input  wire [$clog2(PRF_COUNT)-1:0]     wb_rd_i,
    // issue
    output logic                            iss_valid_o,
    output tag_t                            iss_tag_o,
    output logic [$clog2(PRF_COUNT)-1:0]    iss_rd_o,
    input  wire                             iss_ready_i
);

    localparam int CW = $clog2(QUEUE_DEPTH) + 1;

    logic          alloc;
    logic          src_a_rdy;
    logic          src_b_rdy;
    logic          issue_fire;
    logic          issue_en;
    logic          flush;
    logic [CW-1:0] occupancy;

    busy_table #(
        .PRF_COUNT(PRF_COUNT)
    ) u_busy (
        .aclk(aclk), .rst_n_i(rst_n_i), .flush_i(flush),
        .set_i(alloc), .set_rd_i(disp_rd_i),
        .wb_valid_i(wb_valid_i), .wb_rd_i(wb_rd_i),
        .src_a_i(disp_src_a_i), .src_b_i(disp_src_b_i),
        .src_a_rdy_o(src_a_rdy), .src_b_rdy_o(src_b_rdy)
    );

    issue_queue #(
        .QUEUE_DEPTH(QUEUE_DEPTH), .PRF_COUNT(PRF_COUNT)
    ) u_queue (
        .aclk(aclk), .rst_n_i(rst_n_i), .flush_i(flush), .issue_en_i(issue_en),
        .disp_valid_i(disp_valid_i), .disp_tag_i(disp_tag_i), .disp_rd_i(disp_rd_i),
        .disp_src_a_i(disp_src_a_i), .disp_src_b_i(disp_src_b_i),
        .src_a_rdy_i(src_a_rdy), .src_b_rdy_i(src_b_rdy),
        .disp_ready_o(disp_ready_o), .alloc_o(alloc),
        .wb_valid_i(wb_valid_i), .wb_rd_i(wb_rd_i),
        .iss_valid_o(iss_valid_o), .iss_tag_o(iss_tag_o), .iss_rd_o(iss_rd_o),
        .iss_ready_i(iss_ready_i), .issue_fire_o(issue_fire), .occupancy_o(occupancy)
    );

    iss_csr #(
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) u_csr (
        .aclk(aclk), .rst_n_i(rst_n_i),
        .psel_i(psel_i), .penable_i(penable_i), .pwrite_i(pwrite_i),
        .paddr_i(paddr_i), .pwdata_i(pwdata_i), .prdata_o(prdata_o),
        .occupancy_i(occupancy), .issue_fire_i(issue_fire),
        .issue_en_o(issue_en), .flush_o(flush)
    );

endmodule

`default_nettype wire

// File: tb_issue_props.sv
`default_nettype none
`timescale 1ns/100ps

module tb_issue_props import iss_pkg::*; #(
    parameter int QUEUE_DEPTH = 8
) (
    input  wire                         aclk,
    input  wire                         rst_n_i,
    input  wire                         flush,
    input  wire                         issue_en,
    input  wire                         alloc,
    input  wire                         wb_valid_i,
    input  wire                         iss_valid_o,
    input  wire                         iss_ready_i,
    input  wire [TAG_W-1:0]             iss_tag_o,
    input  wire [$clog2(QUEUE_DEPTH):0] occupancy
);

    int unsigned assert_fails = 0;

    // offer holds under back-pressure unless flush, disable or a wakeup of an older entry
    a_hold: assert property (@(posedge aclk) disable iff (!rst_n_i)
        (iss_valid_o && !iss_ready_i && !flush && !wb_valid_i)
        |=> (!issue_en || (iss_valid_o && $stable(iss_tag_o))))
        else begin
            assert_fails++;
            $error("issue offer dropped or changed while the sink stalled");
        end

    a_occ: assert property (@(posedge aclk) disable iff (!rst_n_i)
        int'(occupancy) <= QUEUE_DEPTH)
        else begin
            assert_fails++;
            $error("queue occupancy above its depth");
        end

    // an accepted dispatch without a same-cycle issue grows the queue by one
    a_alloc: assert property (@(posedge aclk) disable iff (!rst_n_i)
        (alloc && !flush && !(iss_valid_o && iss_ready_i))
        |=> (int'(occupancy) == int'($past(occupancy)) + 1))
        else begin
            assert_fails++;
            $error("accepted dispatch did not add a queue entry");
        end

    // nothing leaves the queue while issue is disabled
    a_enable: assert property (@(posedge aclk) disable iff (!rst_n_i)
        (!issue_en && !flush && !alloc)
        |=> (occupancy == $past(occupancy)))
        else begin
            assert_fails++;
            $error("queue entry removed while issue is disabled");
        end

endmodule

bind issue_stage tb_issue_props #(
    .QUEUE_DEPTH(QUEUE_DEPTH)
) u_props (
    .aclk(aclk), .rst_n_i(rst_n_i), .flush(flush), .issue_en(issue_en),
    .alloc(alloc), .wb_valid_i(wb_valid_i),
    .iss_valid_o(iss_valid_o), .iss_ready_i(iss_ready_i),
    .iss_tag_o(iss_tag_o), .occupancy(occupancy)
);

`default_nettype wire

// File: tb_issue_stage.sv
`default_nettype none
`timescale 1ns/100ps

module tb_issue_stage import iss_pkg::*; ();

    localparam int CLK_PERIOD = 8;
    localparam int RW = $clog2(DEF_PRF_COUNT);
    // the directed tests need a few hundred cycles at most
    localparam int TIMEOUT_CYCLES = 2000;

    logic              aclk;
    logic              rst_n_i;
    logic              psel_i;
    logic              penable_i;
    logic              pwrite_i;
    logic [APB_AW-1:0] paddr_i;
    logic [APB_DW-1:0] pwdata_i;
    logic [APB_DW-1:0] prdata_o;
    logic              disp_valid_i;
    tag_t              disp_tag_i;
    logic [RW-1:0]     disp_rd_i;
    logic [RW-1:0]     disp_src_a_i;
    logic [RW-1:0]     disp_src_b_i;
    logic              disp_ready_o;
    logic              wb_valid_i;
    logic [RW-1:0]     wb_rd_i;
    logic              iss_valid_o;
    tag_t              iss_tag_o;
    logic [RW-1:0]     iss_rd_o;
    logic              iss_ready_i;

    int   errors;
    int   n_issued;
    int   cycles;
    tag_t order_tags [3];

    issue_stage dut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    // inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge aclk);
        #1;
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAILED t=%0t %s: got %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    function automatic tag_t new_tag();
        return tag_t'($urandom());
    endfunction

    task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [APB_DW-1:0] data);
        psel_i   = 1'b1;
        pwrite_i = 1'b1;
        paddr_i  = addr;
        pwdata_i = data;
        next_cycle();
        penable_i = 1'b1;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
        pwrite_i  = 1'b0;
    endtask

    task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [APB_DW-1:0] data);
        psel_i   = 1'b1;
        pwrite_i = 1'b0;
        paddr_i  = addr;
        next_cycle();
        penable_i = 1'b1;
        #1;
        data = prdata_o;
        next_cycle();
        psel_i    = 1'b0;
        penable_i = 1'b0;
    endtask

    task automatic dispatch(input tag_t tag, input logic [RW-1:0] rd,
                            input logic [RW-1:0] src_a, input logic [RW-1:0] src_b);
        disp_valid_i = 1'b1;
        disp_tag_i   = tag;
        disp_rd_i    = rd;
        disp_src_a_i = src_a;
        disp_src_b_i = src_b;
        while (!disp_ready_o) begin
            next_cycle();
        end
        next_cycle();
        disp_valid_i = 1'b0;
    endtask

    task automatic writeback(input logic [RW-1:0] rd);
        wb_valid_i = 1'b1;
        wb_rd_i    = rd;
        next_cycle();
        wb_valid_i = 1'b0;
    endtask

    // takes one issue transfer and compares it with the expected micro-op
    task automatic pop(input tag_t exp_tag, input logic [RW-1:0] exp_rd);
        iss_ready_i = 1'b1;
        while (!iss_valid_o) begin
            next_cycle();
        end
        check("iss_tag_o", 32'(iss_tag_o), 32'(exp_tag));
        check("iss_rd_o", 32'(iss_rd_o), 32'(exp_rd));
        next_cycle();
        iss_ready_i = 1'b0;
        n_issued++;
    endtask

    task automatic test_reset_regs();
        logic [APB_DW-1:0] rdata;
        check("disp_ready_o", 32'(disp_ready_o), 32'd1);
        check("iss_valid_o", 32'(iss_valid_o), 32'd0);
        apb_read(CSR_CTRL_OFS, rdata);
        check("CTRL", rdata, 32'd0);
        apb_read(CSR_STATUS_OFS, rdata);
        check("STATUS", rdata, 32'd0);
        apb_read(CSR_ISSUED_OFS, rdata);
        check("ISSUED", rdata, 32'd0);
        apb_write(CSR_CTRL_OFS, 32'd1);
        apb_read(CSR_CTRL_OFS, rdata);
        check("CTRL", rdata, 32'd1);
        apb_write(CSR_CTRL_OFS, 32'd0);
        apb_read(CSR_CTRL_OFS, rdata);
        check("CTRL", rdata, 32'd0);
        // issue is off so these stay queued
        for (int i = 0; i < 3; i++) begin
            order_tags[i] = new_tag();
            dispatch(order_tags[i], RW'(i + 1), '0, '0);
        end
        apb_read(CSR_STATUS_OFS, rdata);
        check("STATUS", rdata, 32'd3);
        check("iss_valid_o", 32'(iss_valid_o), 32'd0);
    endtask

    task automatic test_program_order();
        tag_t more [3];
        apb_write(CSR_CTRL_OFS, 32'd1);
        for (int i = 0; i < 3; i++) begin
            pop(order_tags[i], RW'(i + 1));
        end
        for (int i = 0; i < 3; i++) begin
            more[i] = new_tag();
            dispatch(more[i], RW'(i + 4), '0, '0);
        end
        for (int i = 0; i < 3; i++) begin
            pop(more[i], RW'(i + 4));
        end
    endtask

    task automatic test_wakeup();
        tag_t prod;
        tag_t waiter;
        tag_t young;
        prod   = new_tag();
        waiter = new_tag();
        young  = new_tag();
        // r9 stays busy after its producer issues, nothing writes it back yet
        dispatch(prod, RW'(9), '0, '0);
        pop(prod, RW'(9));
        dispatch(waiter, RW'(10), RW'(9), '0);
        dispatch(young, RW'(11), '0, '0);
        pop(young, RW'(11));
        check("iss_valid_o", 32'(iss_valid_o), 32'd0);
        writeback(RW'(9));
        check("iss_valid_o", 32'(iss_valid_o), 32'd1);
        pop(waiter, RW'(10));
    endtask

    task automatic test_backpressure();
        logic [APB_DW-1:0] rdata;
        tag_t              bp_tags [8];
        for (int i = 0; i < 8; i++) begin
            bp_tags[i] = new_tag();
        end
        dispatch(bp_tags[0], RW'(20), '0, '0);
        for (int i = 0; i < 4; i++) begin
            check("iss_valid_o", 32'(iss_valid_o), 32'd1);
            check("iss_tag_o", 32'(iss_tag_o), 32'(bp_tags[0]));
            next_cycle();
        end
        for (int i = 1; i < 8; i++) begin
            dispatch(bp_tags[i], RW'(20 + i), '0, '0);
        end
        check("disp_ready_o", 32'(disp_ready_o), 32'd0);
        pop(bp_tags[0], RW'(20));
        check("disp_ready_o", 32'(disp_ready_o), 32'd1);
        apb_read(CSR_STATUS_OFS, rdata);
        check("STATUS", rdata, 32'd7);
    endtask

    task automatic test_flush_counter();
        logic [APB_DW-1:0] rdata;
        tag_t              late;
        late = new_tag();
        apb_write(CSR_FLUSH_OFS, 32'd1);
        apb_read(CSR_STATUS_OFS, rdata);
        check("STATUS", rdata, 32'd0);
        check("iss_valid_o", 32'(iss_valid_o), 32'd0);
        // r21 was still busy when the flush hit
        dispatch(late, RW'(30), RW'(21), '0);
        pop(late, RW'(30));
        apb_read(CSR_ISSUED_OFS, rdata);
        check("ISSUED", rdata, 32'(n_issued));
        apb_write(CSR_ISSUED_OFS, 32'd0);
        apb_read(CSR_ISSUED_OFS, rdata);
        check("ISSUED", rdata, 32'd0);
    endtask

    initial begin
        cycles = 0;
        while (cycles < TIMEOUT_CYCLES) begin
            @(posedge aclk);
            cycles++;
        end
        $display("timeout after %0d cycles, a handshake never completed", cycles);
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        errors   = 0;
        n_issued = 0;
        void'($urandom(40));
        rst_n_i      = 1'b0;
        psel_i       = 1'b0;
        penable_i    = 1'b0;
        pwrite_i     = 1'b0;
        paddr_i      = '0;
        pwdata_i     = '0;
        disp_valid_i = 1'b0;
        disp_tag_i   = '0;
        disp_rd_i    = '0;
        disp_src_a_i = '0;
        disp_src_b_i = '0;
        wb_valid_i   = 1'b0;
        wb_rd_i      = '0;
        iss_ready_i  = 1'b0;
        repeat (2) @(posedge aclk);
        #1;
        rst_n_i = 1'b1;

        test_reset_regs();
        test_program_order();
        test_wakeup();
        test_backpressure();
        test_flush_counter();

        next_cycle();
        $display("check errors: %0d, assertion failures: %0d",
                 errors, dut.u_props.assert_fails);
        if (errors == 0 && dut.u_props.assert_fails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire
